/* verilog.f */
logic/trg_pkg.sv
logic/beat_if.sv
logic/event_if.sv
logic/sample_slicer.sv
logic/trigger_window.sv
logic/event_queue.sv
logic/adc_trigger_top.sv
dv/adc_trigger_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ADC trigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module adc_trigger_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vadc_trigger_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

/* dv/adc_trigger_tb.sv */
module adc_trigger_tb
    import trg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // same values as the DUT defaults
    localparam int THRESHOLD_PCT = 10;
    localparam int THRESHOLD     = 2048 * THRESHOLD_PCT / 100;
    localparam int POST_LEN      = 8;
    localparam int ACQUI_LEN     = 32;
    localparam int CREDIT_INIT   = 2;
    localparam int QUEUE_DEPTH   = 4;
    localparam int NUM_ROWS      = 13;

    typedef struct packed
    {
        stamp_t start;
        len_t   length;
        amp_t   peak;
        logic   trunc;
    } rec_t;

    // amp is relative to the baseline
    // windows is the record count the row should make
    typedef struct packed
    {
        exec_state_t exec;
        sample_t     base;
        int          lead;
        int          hits;
        int          amp;
        int          lane;
        logic        hold;
        int          windows;
    } row_t;

    row_t rows [NUM_ROWS] = '{
        '{EXEC_RUN,     12'sd0,   4,  3, 500, 2, 1'b0, 1},
        '{EXEC_RUN,     12'sd100, 4,  1, 203, 5, 1'b0, 0},
        '{EXEC_RUN,     12'sd100, 4,  1, 204, 5, 1'b0, 1},
        '{EXEC_CALIB,   12'sd0,   4,  5, 700, 1, 1'b0, 0},
        '{EXEC_RUN,    -12'sd50,  4, 40, 300, 7, 1'b0, 2},
        '{EXEC_RUN,     12'sd20,  4,  2, 310, 0, 1'b1, 1},
        '{EXEC_RUN,     12'sd20,  4,  2, 320, 1, 1'b1, 1},
        '{EXEC_RUN,     12'sd20,  4,  2, 330, 2, 1'b1, 1},
        '{EXEC_RUN,     12'sd20,  4,  2, 340, 3, 1'b1, 1},
        '{EXEC_RUN,     12'sd20,  4,  2, 350, 4, 1'b1, 1},
        '{EXEC_RUN,     12'sd20,  4,  2, 360, 5, 1'b1, 1},
        '{EXEC_RUN,     12'sd20,  4,  2, 370, 6, 1'b1, 1},
        '{EXEC_RUN,     12'sd0,  20,  1, 250, 3, 1'b0, 1}
    };

    logic        aclk;
    logic        aresetn;
    exec_state_t exec_state;
    sample_t     baseline;
    stamp_t      current_time;
    tdata_t      s_axis_tdata;
    logic        evt_credit = 1'b0;
    logic        evt_valid;
    stamp_t      evt_start_time;
    len_t        evt_length;
    amp_t        evt_peak;
    logic        evt_truncated;
    logic [7:0]  drop_count;
    logic        trigger_active;

    rec_t   exp_q [$];
    rec_t   got_q [$];
    stamp_t hit_stamps [$];
    logic   hold = 1'b0;
    logic   calib_trigger = 1'b0;
    logic   active_q = 1'b0;
    int     opened = 0;
    int     returned = 0;
    int     next_stamp = 1;
    int     exp_drops = 0;
    int     errors = 0;
    int     checked = 0;
    int     cycles = 0;
    int     cycle_limit = 200;

    adc_trigger_top dut
    (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .exec_state     (exec_state),
        .baseline       (baseline),
        .current_time   (current_time),
        .s_axis_tdata   (s_axis_tdata),
        .evt_credit     (evt_credit),
        .evt_valid      (evt_valid),
        .evt_start_time (evt_start_time),
        .evt_length     (evt_length),
        .evt_peak       (evt_peak),
        .evt_truncated  (evt_truncated),
        .drop_count     (drop_count),
        .trigger_active (trigger_active)
    );

    initial
    begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    task automatic check_stamp(input string name, input stamp_t got, input stamp_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_amp(input string name, input amp_t got, input amp_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // records the consumer can have taken so far with the credits it returned
    function automatic int deliverable();
        int granted;
        granted = CREDIT_INIT + returned;
        return (exp_q.size() < granted) ? exp_q.size() : granted;
    endfunction

    task automatic drive_beat(input row_t row, input logic is_hit);
        tdata_t data;
        int     value;
        for (int i = 0; i < LANE_COUNT; i++)
        begin
            // noise stays well under the threshold
            value = int'($urandom % 150) - 50;
            if (is_hit && i == row.lane)
            begin
                value = row.amp;
            end
            data[LANE_BITS*i +: LANE_BITS] = {sample_t'(int'(row.base) + value), 4'h0};
        end
        @(posedge aclk);
        exec_state   <= row.exec;
        baseline     <= row.base;
        s_axis_tdata <= data;
        current_time <= stamp_t'(next_stamp);
        hold         <= row.hold;
        if (is_hit)
        begin
            hit_stamps.push_back(stamp_t'(next_stamp));
        end
        next_stamp++;
    endtask

    // window rule applied to one contiguous run of hit beats
    task automatic expect_row(input row_t row);
        int   remaining;
        int   windows;
        rec_t rec;
        remaining = (row.exec == EXEC_RUN && row.amp >= THRESHOLD) ? row.hits : 0;
        windows   = 0;
        while (remaining > 0)
        begin
            rec.start = hit_stamps[windows * ACQUI_LEN];
            rec.peak  = amp_t'(row.amp);
            if (remaining + POST_LEN <= ACQUI_LEN)
            begin
                rec.length = len_t'(remaining + POST_LEN);
                rec.trunc  = 1'b0;
                remaining  = 0;
            end
            else
            begin
                rec.length = len_t'(ACQUI_LEN);
                rec.trunc  = 1'b1;
                remaining  = (remaining > ACQUI_LEN) ? remaining - ACQUI_LEN : 0;
            end
            // full FIFO and no credit left
            if (exp_q.size() - deliverable() >= QUEUE_DEPTH)
            begin
                exp_drops++;
            end
            else
            begin
                exp_q.push_back(rec);
            end
            windows++;
        end
    endtask

    // record monitor and credit return
    always @(posedge aclk)
    begin
        rec_t rec;
        evt_credit <= 1'b0;
        if (evt_valid)
        begin
            rec.start  = evt_start_time;
            rec.length = evt_length;
            rec.peak   = evt_peak;
            rec.trunc  = evt_truncated;
            got_q.push_back(rec);
        end
        if (!hold && returned < got_q.size())
        begin
            evt_credit <= 1'b1;
            returned   <= returned + 1;
        end
        if (exec_state == EXEC_CALIB && trigger_active)
        begin
            calib_trigger <= 1'b1;
        end
        // each rise of trigger_active is one window opening
        active_q <= trigger_active;
        if (trigger_active && !active_q)
        begin
            opened <= opened + 1;
        end
    end

    always @(posedge aclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        int err_before;
        int opened_before;
        aresetn      = 1'b0;
        exec_state   = EXEC_CALIB;
        baseline     = '0;
        current_time = '0;
        s_axis_tdata = '0;
        void'($urandom(32'h34ab));
        foreach (rows[i])
        begin
            cycle_limit += rows[i].lead + rows[i].hits + POST_LEN + 4;
        end
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;

        foreach (rows[r])
        begin
            err_before    = errors;
            opened_before = opened;
            hit_stamps.delete();
            for (int b = 0; b < rows[r].lead; b++)
            begin
                drive_beat(rows[r], 1'b0);
            end
            for (int b = 0; b < rows[r].hits; b++)
            begin
                drive_beat(rows[r], 1'b1);
            end
            for (int b = 0; b < POST_LEN + 4; b++)
            begin
                drive_beat(rows[r], 1'b0);
            end
            expect_row(rows[r]);
            @(negedge aclk);
            while (got_q.size() < deliverable())
            begin
                @(negedge aclk);
            end
            while (checked < got_q.size() && checked < exp_q.size())
            begin
                check_stamp("evt_start_time", got_q[checked].start, exp_q[checked].start);
                check_len("evt_length", got_q[checked].length, exp_q[checked].length);
                check_amp("evt_peak", got_q[checked].peak, exp_q[checked].peak);
                check_flag("evt_truncated", got_q[checked].trunc, exp_q[checked].trunc);
                checked++;
            end
            if (got_q.size() > exp_q.size())
            begin
                $display("more records arrived than the window rule allows");
                errors++;
            end
            check_count("trigger_active openings", 8'(opened - opened_before),
                        8'(rows[r].windows));
            if (rows[r].exec == EXEC_CALIB)
            begin
                check_flag("trigger_active", calib_trigger, 1'b0);
            end
            $display("test %0d %s, %0d records checked so far", r,
                     (errors == err_before) ? "ok" : "failed", checked);
        end

        check_count("drop_count", drop_count, 8'(exp_drops));
        if (got_q.size() != exp_q.size())
        begin
            $display("%0d records arrived where %0d were expected", got_q.size(), exp_q.size());
            errors++;
        end
        $display("%0d tests, %0d records checked, %0d errors", NUM_ROWS, checked, errors);
        if (errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* logic/adc_trigger_top.sv */
module adc_trigger_top
    import trg_pkg::*;
#(
    parameter int THRESHOLD_PCT = 10,
    parameter int POST_LEN      = 8,
    parameter int ACQUI_LEN     = 32,
    parameter int CREDIT_INIT   = 2
)
(
    input  logic        aclk,
    input  logic        aresetn,
    input  exec_state_t exec_state,
    input  sample_t     baseline,
    input  stamp_t      current_time,
    input  tdata_t      s_axis_tdata,
    input  logic        evt_credit,
    output logic        evt_valid,
    output stamp_t      evt_start_time,
    output len_t        evt_length,
    output amp_t        evt_peak,
    output logic        evt_truncated,
    output logic [7:0]  drop_count,
    output logic        trigger_active
);

    beat_if  beat_bus ();
    event_if rec_bus ();

    // decode, one cycle
    sample_slicer #(
        .THRESHOLD_PCT (THRESHOLD_PCT)
    ) u_slicer (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .exec_state   (exec_state),
        .baseline     (baseline),
        .current_time (current_time),
        .s_axis_tdata (s_axis_tdata),
        .beat         (beat_bus)
    );

    // window FSM, record one cycle after the closing beat
    trigger_window #(
        .POST_LEN  (POST_LEN),
        .ACQUI_LEN (ACQUI_LEN)
    ) u_window (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .beat           (beat_bus),
        .rec            (rec_bus),
        .trigger_active (trigger_active)
    );

    // record FIFO with credit release
    event_queue #(
        .CREDIT_INIT (CREDIT_INIT)
    ) u_queue (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .rec            (rec_bus),
        .evt_credit     (evt_credit),
        .evt_valid      (evt_valid),
        .evt_start_time (evt_start_time),
        .evt_length     (evt_length),
        .evt_peak       (evt_peak),
        .evt_truncated  (evt_truncated),
        .drop_count     (drop_count)
    );

endmodule

/* logic/event_queue.sv */
module event_queue
    import trg_pkg::*;
#(
    parameter int CREDIT_INIT = 2
)
(
    input  logic       aclk,
    input  logic       aresetn,
    event_if.sink      rec,
    input  logic       evt_credit,
    output logic       evt_valid,
    output stamp_t     evt_start_time,
    output len_t       evt_length,
    output amp_t       evt_peak,
    output logic       evt_truncated,
    output logic [7:0] drop_count
);

    localparam int DEPTH    = 4;
    localparam int PTR_BITS = $clog2(DEPTH);

    stamp_t              fifo_start [DEPTH];
    len_t                fifo_len [DEPTH];
    amp_t                fifo_peak [DEPTH];
    logic [DEPTH-1:0]    fifo_trunc;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   fill;
    logic [7:0]          credits;
    logic                full;
    logic                push;
    logic                send;

    assign full = fill == (PTR_BITS + 1)'(DEPTH);
    assign push = rec.rec_valid && !full;
    // one record per credit, oldest first
    assign send = (fill != '0) && (credits != '0);

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            credits    <= 8'(CREDIT_INIT);
            drop_count <= '0;
            evt_valid  <= 1'b0;
        end
        else
        begin
            wr_ptr    <= wr_ptr + PTR_BITS'(push);
            rd_ptr    <= rd_ptr + PTR_BITS'(send);
            fill      <= fill + (PTR_BITS + 1)'(push) - (PTR_BITS + 1)'(send);
            // return and spend together cancel out
            credits   <= credits + 8'(evt_credit) - 8'(send);
            evt_valid <= send;
            if (rec.rec_valid && full && drop_count != 8'hff)
            begin
                drop_count <= drop_count + 8'd1;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            fifo_start[wr_ptr] <= rec.rec_start;
            fifo_len[wr_ptr]   <= rec.rec_length;
            fifo_peak[wr_ptr]  <= rec.rec_peak;
            fifo_trunc[wr_ptr] <= rec.rec_truncated;
        end
        if (send)
        begin
            evt_start_time <= fifo_start[rd_ptr];
            evt_length     <= fifo_len[rd_ptr];
            evt_peak       <= fifo_peak[rd_ptr];
            evt_truncated  <= fifo_trunc[rd_ptr];
        end
    end

endmodule

/* logic/trigger_window.sv */
module trigger_window
    import trg_pkg::*;
#(
    parameter int POST_LEN  = 8,
    parameter int ACQUI_LEN = 32
)
(
    input  logic    aclk,
    input  logic    aresetn,
    beat_if.sink    beat,
    event_if.source rec,
    output logic    trigger_active
);

    localparam int QUIET_BITS = $clog2(POST_LEN + 1);

    win_state_t            state;
    logic [QUIET_BITS-1:0] quiet_cnt;
    len_t                  len_cnt;
    amp_t                  peak;
    stamp_t                start;
    len_t                  len_next;
    amp_t                  peak_next;
    logic                  quiet_done;
    logic                  len_done;

    // length and peak including the beat now presented
    always_comb
    begin
        len_next   = len_cnt + len_t'(1);
        peak_next  = (beat.hit && beat.beat_peak > peak) ? beat.beat_peak : peak;
        quiet_done = !beat.hit && (quiet_cnt == QUIET_BITS'(POST_LEN - 1));
        len_done   = len_next == len_t'(ACQUI_LEN);
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state         <= WIN_IDLE;
            quiet_cnt     <= '0;
            len_cnt       <= '0;
            rec.rec_valid <= 1'b0;
        end
        else
        begin
            rec.rec_valid <= 1'b0;
            if (beat.beat_valid)
            begin
                case (state)
                    WIN_IDLE:
                    begin
                        if (beat.hit)
                        begin
                            state     <= WIN_OPEN;
                            len_cnt   <= len_t'(1);
                            quiet_cnt <= '0;
                        end
                    end
                    WIN_OPEN:
                    begin
                        len_cnt   <= len_next;
                        quiet_cnt <= beat.hit ? '0 : quiet_cnt + 1'b1;
                        // natural end or forced end, next beat may reopen
                        if (quiet_done || len_done)
                        begin
                            state         <= WIN_IDLE;
                            rec.rec_valid <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // while idle, start and peak follow each beat until a hit opens the window
    always_ff @(posedge aclk)
    begin
        if (beat.beat_valid)
        begin
            if (state == WIN_IDLE)
            begin
                start <= beat.beat_time;
                peak  <= beat.beat_peak;
            end
            else
            begin
                peak              <= peak_next;
                rec.rec_start     <= start;
                rec.rec_length    <= len_next;
                rec.rec_peak      <= peak_next;
                // quiet close wins when both land on the same beat
                rec.rec_truncated <= len_done && !quiet_done;
            end
        end
    end

    assign trigger_active = (state == WIN_OPEN);

endmodule

/* logic/sample_slicer.sv */
module sample_slicer
    import trg_pkg::*;
#(
    parameter int THRESHOLD_PCT = 10
)
(
    input  logic        aclk,
    input  logic        aresetn,
    input  exec_state_t exec_state,
    input  sample_t     baseline,
    input  stamp_t      current_time,
    input  tdata_t      s_axis_tdata,
    beat_if.source      beat
);

    // percent of positive full scale, integer division
    localparam int   FULL_SCALE = 2 ** (ADC_BITS - 1);
    localparam amp_t THRESHOLD  = amp_t'(FULL_SCALE * THRESHOLD_PCT / 100);

    sample_t               lane_sample [LANE_COUNT];
    amp_t                  lane_amp [LANE_COUNT];
    logic [LANE_COUNT-1:0] lane_over;
    amp_t                  peak_comb;
    logic                  hit_comb;

    // sample sits in the upper bits of each 16-bit lane
    always_comb
    begin
        peak_comb = '0;
        for (int i = 0; i < LANE_COUNT; i++)
        begin
            lane_sample[i] = s_axis_tdata[LANE_BITS*i + LANE_BITS - 1 -: ADC_BITS];
            lane_amp[i]    = amp_t'(lane_sample[i]) - amp_t'(baseline);
            lane_over[i]   = lane_amp[i] >= THRESHOLD;
            if (i == 0 || lane_amp[i] > peak_comb)
            begin
                peak_comb = lane_amp[i];
            end
        end
        // calibration keeps the trigger quiet
        hit_comb = (exec_state == EXEC_RUN) && (|lane_over);
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            beat.hit        <= 1'b0;
            beat.beat_valid <= 1'b0;
        end
        else
        begin
            beat.hit        <= hit_comb;
            beat.beat_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        beat.beat_peak <= peak_comb;
        beat.beat_time <= current_time;
    end

endmodule

/* logic/event_if.sv */
interface event_if
    import trg_pkg::*;
();

    // single cycle strobe per closed window
    logic   rec_valid;
    stamp_t rec_start;
    len_t   rec_length;
    amp_t   rec_peak;
    // window hit the maximum length
    logic   rec_truncated;

    modport source
    (
        output rec_valid, rec_start, rec_length, rec_peak, rec_truncated
    );

    // no ready here, the queue drops what it cannot hold
    modport sink
    (
        input rec_valid, rec_start, rec_length, rec_peak, rec_truncated
    );

endinterface

/* logic/beat_if.sv */
interface beat_if
    import trg_pkg::*;
();

    // some lane at or over threshold, only in run state
    logic   hit;
    // largest corrected lane amplitude of the beat
    amp_t   beat_peak;
    stamp_t beat_time;
    // low on the first cycle out of reset
    logic   beat_valid;

    modport source
    (
        output hit, beat_peak, beat_time, beat_valid
    );

    modport sink
    (
        input hit, beat_peak, beat_time, beat_valid
    );

endinterface

/* logic/trg_pkg.sv */
package trg_pkg;

    // converter resolution and stream layout
    localparam int ADC_BITS   = 12;
    localparam int LANE_COUNT = 8;
    localparam int TDATA_BITS = 128;
    localparam int LANE_BITS  = TDATA_BITS / LANE_COUNT;

    // event record field widths
    localparam int STAMP_BITS = 16;
    localparam int LEN_BITS   = 8;

    // one raw sample, or the baseline
    typedef logic signed [ADC_BITS-1:0] sample_t;

    // baseline corrected amplitude, one bit wider so the subtraction cannot wrap
    typedef logic signed [ADC_BITS:0] amp_t;

    typedef logic [STAMP_BITS-1:0] stamp_t;

    // window length in beats
    typedef logic [LEN_BITS-1:0] len_t;

    typedef logic [TDATA_BITS-1:0] tdata_t;

    // run control from the host side
    typedef enum logic [1:0]
    {
        EXEC_CALIB = 2'b00,
        EXEC_RUN   = 2'b11
    } exec_state_t;

    // acquisition window FSM
    typedef enum logic
    {
        WIN_IDLE = 1'b0,
        WIN_OPEN = 1'b1
    } win_state_t;

endpackage
